//--- logic/uart_line_pkg.sv
////////////////////////////////////////
// Serial line format of the UART
// Data byte type, parity and stop-bit options and the FSM state
// encodings of the transmit and receive paths
// Imported inside the module bodies that need it
////////////////////////////////////////
`default_nettype none

package uart_line_pkg;

    // One data byte, always sent LSB first
    typedef logic [7:0] byte_t;

    typedef enum logic [1:0]
    {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,   // Ones in data plus parity even
        PARITY_ODD  = 2'd2    // Ones in data plus parity odd
    } parity_mode_t;

    typedef enum logic
    {
        STOP_ONE = 1'b0,
        STOP_TWO = 1'b1
    } stop_bits_t;

    ////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////

    typedef enum logic [2:0]
    {
        TX_IDLE   = 3'd0,
        TX_START  = 3'd1,
        TX_DATA   = 3'd2,
        TX_PARITY = 3'd3,
        TX_STOP   = 3'd4
    } tx_state_t;

    typedef enum logic [2:0]
    {
        RX_IDLE   = 3'd0,
        RX_START  = 3'd1,   // Waiting to confirm start at mid-bit
        RX_DATA   = 3'd2,
        RX_PARITY = 3'd3,
        RX_STOP   = 3'd4    // Only the first stop bit is checked
    } rx_state_t;

endpackage

`default_nettype wire

//--- logic/uart_host_pkg.sv
////////////////////////////////////////
// Host side types of the UART
// Receive event strobes and receive FIFO status
// FIFO_DEPTH_MAX bounds the depth the status count can show
////////////////////////////////////////
`default_nettype none

package uart_host_pkg;

    localparam int FIFO_DEPTH_MAX = 64;
    localparam int FIFO_COUNT_W   = $clog2(FIFO_DEPTH_MAX + 1);

    // Each field is a one-cycle strobe
    typedef struct packed
    {
        logic parity_err;
        logic frame_err;
        logic overrun;   // Good byte dropped, FIFO full
    } rx_event_t;

    typedef struct packed
    {
        logic                    empty;
        logic                    full;
        logic [FIFO_COUNT_W-1:0] count;   // Bytes held
    } fifo_status_t;

endpackage

`default_nettype wire

//--- logic/uart_bit_timer.sv
////////////////////////////////////////
// Bit period counter shared by both paths
// A restart strobe zeroes the count, after which bit_end pulses
// every CLKS_PER_BIT cycles and mid_bit at the half-way count
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_bit_timer #(
    parameter int CLKS_PER_BIT = 434
)
(
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic mid_bit,
    output logic bit_end
);

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
            cnt <= '0;
        else if (restart || (cnt == LAST))
            cnt <= '0;   // Wraps every bit period
        else
            cnt <= cnt + 1'b1;
    end

    assign mid_bit = (cnt == HALF);
    assign bit_end = (cnt == LAST);

    a_strobes_apart: assert property (@(posedge clk) disable iff (rst)
        !(mid_bit && bit_end));

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
////////////////////////////////////////
// UART transmit path
// A tx_start strobe while idle latches the byte; the start bit
// goes out on the next cycle, then 8 data bits LSB first, the
// optional parity bit and one or two stop bits
// Strobes while busy are ignored
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int                          CLKS_PER_BIT = 434,
    parameter uart_line_pkg::parity_mode_t PARITY       = uart_line_pkg::PARITY_EVEN,
    parameter uart_line_pkg::stop_bits_t   STOP_BITS    = uart_line_pkg::STOP_ONE
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_start,
    input  uart_line_pkg::byte_t tx_data,
    output logic                 tx_busy,
    output logic                 tx
);

    import uart_line_pkg::*;

    tx_state_t  state;
    byte_t      shreg;     // Remaining data bits
    logic       par_bit;
    logic [2:0] bit_cnt;   // Data bit index, reused for stop bits
    logic       accept;
    logic       bit_end;

    assign accept  = tx_start && (state == TX_IDLE);
    assign tx_busy = (state != TX_IDLE);

    uart_bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) timer
    (
        .clk     (clk),
        .rst     (rst),
        .restart (accept),
        .mid_bit (),
        .bit_end (bit_end)
    );

    // Byte and parity latched once per frame
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            shreg   <= tx_data;
            par_bit <= (^tx_data) ^ (PARITY == PARITY_ODD);
        end
        else if (bit_end && ((state == TX_START) || (state == TX_DATA)))
            shreg <= shreg >> 1;
    end

    ////////////////////////////////////////
    // Frame FSM, steps on bit_end
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= TX_IDLE;
            tx      <= 1'b1;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    if (tx_start)
                    begin
                        state <= TX_START;
                        tx    <= 1'b0;   // Start bit
                    end
                end
                TX_START:
                begin
                    if (bit_end)
                    begin
                        state   <= TX_DATA;
                        tx      <= shreg[0];
                        bit_cnt <= '0;
                    end
                end
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            bit_cnt <= '0;
                            if (PARITY != PARITY_NONE)
                            begin
                                state <= TX_PARITY;
                                tx    <= par_bit;
                            end
                            else
                            begin
                                state <= TX_STOP;
                                tx    <= 1'b1;
                            end
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shreg[0];
                        end
                    end
                end
                TX_PARITY:
                begin
                    if (bit_end)
                    begin
                        state <= TX_STOP;
                        tx    <= 1'b1;
                    end
                end
                TX_STOP:
                begin
                    if (bit_end)
                    begin
                        if ((STOP_BITS == STOP_TWO) && (bit_cnt == 3'd0))
                            bit_cnt <= 3'd1;   // Second stop bit
                        else
                            state <= TX_IDLE;
                    end
                end
                default:
                begin
                    state <= TX_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

    a_idle_mark: assert property (@(posedge clk) disable iff (rst)
        (state == TX_IDLE) |-> tx);

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
////////////////////////////////////////
// UART receive path
// Synchronizes rx, finds the start edge and samples every bit
// at mid-bit; a good byte leaves as a push strobe with its data,
// a bad one as a parity_err or frame_err strobe
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int                          CLKS_PER_BIT = 434,
    parameter uart_line_pkg::parity_mode_t PARITY       = uart_line_pkg::PARITY_EVEN
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output logic                 push,
    output uart_line_pkg::byte_t push_data,
    output logic                 parity_err,
    output logic                 frame_err
);

    import uart_line_pkg::*;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    byte_t      shreg;
    logic [2:0] bit_cnt;
    logic       par_bad;      // Held until the stop bit
    logic       start_edge;
    logic       mid_bit;
    logic       stop_check;

    // Two-flop synchronizer plus edge history, idle line is high
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = (state == RX_IDLE) && rx_prev && !rx_sync;

    uart_bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) timer
    (
        .clk     (clk),
        .rst     (rst),
        .restart (start_edge),
        .mid_bit (mid_bit),
        .bit_end ()
    );

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if ((state == RX_DATA) && mid_bit)
            shreg <= {rx_sync, shreg[7:1]};
    end

    ////////////////////////////////////////
    // Frame FSM, steps on mid_bit
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            par_bad <= 1'b0;
        end
        else
        begin
            case (state)
                RX_IDLE:
                begin
                    if (start_edge)
                    begin
                        state   <= RX_START;
                        par_bad <= 1'b0;
                    end
                end
                RX_START:
                begin
                    if (mid_bit)
                    begin
                        bit_cnt <= '0;
                        if (!rx_sync)
                            state <= RX_DATA;
                        else
                            state <= RX_IDLE;   // Glitch, not a start bit
                    end
                end
                RX_DATA:
                begin
                    if (mid_bit)
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            if (PARITY != PARITY_NONE)
                                state <= RX_PARITY;
                            else
                                state <= RX_STOP;
                        end
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_PARITY:
                begin
                    if (mid_bit)
                    begin
                        par_bad <= rx_sync != ((^shreg) ^ (PARITY == PARITY_ODD));
                        state   <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    if (mid_bit)
                        state <= RX_IDLE;   // Rest of the stop bit is idle line
                end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // Verdict at the middle of the first stop bit
    assign stop_check = (state == RX_STOP) && mid_bit;
    assign frame_err  = stop_check && !rx_sync;
    assign parity_err = stop_check && par_bad;
    assign push       = stop_check && rx_sync && !par_bad;
    assign push_data  = shreg;

    a_push_clean: assert property (@(posedge clk) disable iff (rst)
        push |-> !(parity_err || frame_err));

endmodule

`default_nettype wire

//--- logic/uart_rx_fifo.sv
////////////////////////////////////////
// Receive FIFO, first word fall-through
// head shows the oldest byte while status.empty is low; pop
// removes it; a push while full is dropped and strobes overrun
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo #(
    parameter int FIFO_DEPTH = 16   // Power of two
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  uart_line_pkg::byte_t        push_data,
    input  logic                        pop,
    output uart_line_pkg::byte_t        head,
    output uart_host_pkg::fifo_status_t status,
    output logic                        overrun
);

    import uart_line_pkg::*;
    import uart_host_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [FIFO_COUNT_W-1:0] DEPTH = FIFO_COUNT_W'(FIFO_DEPTH);

    if (FIFO_DEPTH > FIFO_DEPTH_MAX)
    begin : g_depth_check
        $error("FIFO_DEPTH above FIFO_DEPTH_MAX");
    end

    byte_t                   mem [FIFO_DEPTH];
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [FIFO_COUNT_W-1:0] count;
    logic                    empty;
    logic                    full;
    logic                    do_push;
    logic                    do_pop;

    assign empty   = (count == '0);
    assign full    = (count == DEPTH);
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);   // Pop frees the slot
    assign overrun = push && !do_push;

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at the power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    assign head   = mem[rd_ptr];
    assign status = '{empty: empty, full: full, count: count};

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= DEPTH);

endmodule

`default_nettype wire

//--- logic/uart_rs232_top.sv
////////////////////////////////////////
// RS-232 UART top level
// Host side uses single-cycle strobes: tx_start, rx_read and the
// rx_event fields; rx_data shows the receive FIFO head
// cts follows rts and FIFO room when FLOW_CONTROL is set
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_rs232_top #(
    parameter int                          CLKS_PER_BIT = 434,
    parameter uart_line_pkg::parity_mode_t PARITY       = uart_line_pkg::PARITY_EVEN,
    parameter uart_line_pkg::stop_bits_t   STOP_BITS    = uart_line_pkg::STOP_ONE,
    parameter int                          FIFO_DEPTH   = 16,
    parameter bit                          FLOW_CONTROL = 1'b0
)
(
    input  logic                        clk,
    input  logic                        rst,
    // Host transmit side
    input  logic                        tx_start,
    input  uart_line_pkg::byte_t        tx_data,
    output logic                        tx_busy,
    // Host receive side
    input  logic                        rx_read,
    output uart_line_pkg::byte_t        rx_data,
    output uart_host_pkg::fifo_status_t rx_status,
    output uart_host_pkg::rx_event_t    rx_event,
    // Line side
    output logic                        tx,
    input  logic                        rx,
    input  logic                        rts,
    output logic                        cts
);

    import uart_line_pkg::*;

    logic  push;
    byte_t push_data;
    logic  parity_err;
    logic  frame_err;
    logic  overrun;

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY),
        .STOP_BITS    (STOP_BITS)
    ) u_tx
    (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY)
    ) u_rx
    (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .push       (push),
        .push_data  (push_data),
        .parity_err (parity_err),
        .frame_err  (frame_err)
    );

    uart_rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (rx_read),
        .head      (rx_data),
        .status    (rx_status),
        .overrun   (overrun)
    );

    assign rx_event = '{parity_err: parity_err, frame_err: frame_err, overrun: overrun};

    // Registered, one cycle behind rts and FIFO full
    always_ff @(posedge clk)
    begin
        if (rst)
            cts <= 1'b0;
        else if (FLOW_CONTROL)
            cts <= rts && !rx_status.full;
        else
            cts <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/uart_rs232_tb.sv
////////////////////////////////////////
// Testbench for the RS-232 UART top level
// Drives the host strobes and a bit-banged or looped-back line;
// concurrent assertions compare against expected values
// TB_PARITY (0 none, 1 even, 2 odd) and TB_STOP (0 one, 1 two) pick the format
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_rs232_tb #(
    parameter int TB_PARITY = 0,
    parameter int TB_STOP   = 0
);

    import uart_line_pkg::*;
    import uart_host_pkg::*;

    localparam int C      = 8;   // Clocks per bit
    localparam int P_BITS = (TB_PARITY != 0) ? 1 : 0;
    localparam int S_BITS = (TB_STOP != 0) ? 2 : 1;
    localparam int NB     = 9 + P_BITS + S_BITS;   // Bits per frame
    localparam int LIMIT  = 4 * NB * C;

    logic         clk;
    logic         rst;
    logic         tx_start;
    byte_t        tx_data;
    logic         tx_busy;
    logic         rx_read;
    byte_t        rx_data;
    fifo_status_t rx_status;
    rx_event_t    rx_event;
    logic         tx;
    logic         rx_line;
    logic         rts;
    logic         cts;
    logic         bb_line;
    logic         loopback;   // 1 routes tx back into rx

    // Expected values and check enables
    logic                    rst_chk;
    logic                    tx_chk;
    logic                    tx_exp;
    logic                    len_chk;
    int                      busy_len;
    int                      len_exp;
    logic                    data_chk;
    byte_t                   data_exp;
    logic                    quiet;
    logic                    empty_chk;
    logic                    cts_chk;
    logic                    cts_exp;
    logic                    cnt_chk;
    logic [FIFO_COUNT_W-1:0] cnt_exp;
    logic                    full_exp;

    int          cyc;
    int          errors;
    int          tests;
    int          failed;
    logic [31:0] rng;
    logic [15:0] frame_bits;   // Bit i is line bit i of the frame

    assign rx_line = loopback ? tx : bb_line;

    uart_rs232_top #(
        .CLKS_PER_BIT (C),
        .PARITY       (parity_mode_t'(TB_PARITY)),
        .STOP_BITS    (stop_bits_t'(TB_STOP)),
        .FIFO_DEPTH   (4),
        .FLOW_CONTROL (1'b1)
    ) UUT
    (
        .clk       (clk),
        .rst       (rst),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .rx_read   (rx_read),
        .rx_data   (rx_data),
        .rx_status (rx_status),
        .rx_event  (rx_event),
        .tx        (tx),
        .rx        (rx_line),
        .rts       (rts),
        .cts       (cts)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_rst_tx: assert property (@(posedge clk) rst_chk |-> tx)
    else
    begin
        $display("[FAIL] %0t tx exp 1 got %b", $time, tx);
        errors++;
    end
    a_rst_busy: assert property (@(posedge clk) rst_chk |-> !tx_busy)
    else
    begin
        $display("[FAIL] %0t tx_busy exp 0 got %b", $time, tx_busy);
        errors++;
    end
    a_rst_cts: assert property (@(posedge clk) rst_chk |-> !cts)
    else
    begin
        $display("[FAIL] %0t cts exp 0 got %b", $time, cts);
        errors++;
    end
    a_tx_bit: assert property (@(posedge clk) tx_chk |-> (tx == tx_exp))
    else
    begin
        $display("[FAIL] %0t tx exp %b got %b", $time, tx_exp, tx);
        errors++;
    end
    a_busy_len: assert property (@(posedge clk)
        len_chk |-> (busy_len >= len_exp) && (busy_len <= len_exp + 1))
    else
    begin
        $display("[FAIL] %0t tx_busy length exp %0d got %0d", $time, len_exp, busy_len);
        errors++;
    end
    a_rx_data: assert property (@(posedge clk) data_chk |-> (rx_data == data_exp))
    else
    begin
        $display("[FAIL] %0t rx_data exp %h got %h", $time, data_exp, rx_data);
        errors++;
    end
    a_quiet: assert property (@(posedge clk) quiet |-> (rx_event == '0))
    else
    begin
        $display("[FAIL] %0t rx_event exp 000 got %b", $time, rx_event);
        errors++;
    end
    a_empty: assert property (@(posedge clk) empty_chk |-> rx_status.empty)
    else
    begin
        $display("[FAIL] %0t rx_status.empty exp 1 got %b", $time, rx_status.empty);
        errors++;
    end
    a_cts: assert property (@(posedge clk) cts_chk |-> (cts == cts_exp))
    else
    begin
        $display("[FAIL] %0t cts exp %b got %b", $time, cts_exp, cts);
        errors++;
    end
    a_count: assert property (@(posedge clk) cnt_chk |-> (rx_status.count == cnt_exp))
    else
    begin
        $display("[FAIL] %0t rx_status.count exp %0d got %0d", $time, cnt_exp,
                 rx_status.count);
        errors++;
    end
    a_full: assert property (@(posedge clk) cnt_chk |-> (rx_status.full == full_exp))
    else
    begin
        $display("[FAIL] %0t rx_status.full exp %b got %b", $time, full_exp,
                 rx_status.full);
        errors++;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Start, 8 data LSB first, parity, stop bits
    task automatic build_frame(input byte_t b);
        int ones;
        ones = 0;
        frame_bits = '1;
        frame_bits[0] = 1'b0;
        for (int k = 0; k < 8; k++)
        begin
            frame_bits[k+1] = b[k];
            if (b[k])
                ones++;
        end
        if (TB_PARITY == 1)
            frame_bits[9] = ones[0];    // Even total
        else if (TB_PARITY == 2)
            frame_bits[9] = !ones[0];   // Odd total
    endtask

    task automatic send_tx_byte(input byte_t b, input bit interfere);
        int n;
        int e0;
        build_frame(b);
        tx_data  = b;
        tx_start = 1'b1;
        tick();
        tx_start = 1'b0;
        n = 0;
        while ((tx !== 1'b0) && (n < LIMIT))
        begin
            tick();
            n++;
        end
        if (n >= LIMIT)
        begin
            $display("Timeout waiting for the start bit on tx");
            errors++;
            return;
        end
        e0 = cyc;
        repeat (C/2 - 1) tick();
        for (int i = 0; i < NB; i++)
        begin
            tx_exp = frame_bits[i];
            tx_chk = 1'b1;
            if (interfere && (i == 3))
            begin
                tx_start = 1'b1;   // Must be ignored while busy
                tx_data  = ~b;
            end
            tick();
            tx_chk   = 1'b0;
            tx_start = 1'b0;
            if (i < NB - 1)
                repeat (C - 1) tick();
        end
        n = 0;
        while (tx_busy && (n < LIMIT))
        begin
            tick();
            n++;
        end
        if (n >= LIMIT)
        begin
            $display("Timeout waiting for tx_busy to fall");
            errors++;
        end
        busy_len = cyc - e0;
        len_exp  = NB * C;
        len_chk  = 1'b1;
        tick();
        len_chk  = 1'b0;
        // No second frame may follow
        tx_exp = 1'b1;
        tx_chk = 1'b1;
        repeat (2 * C) tick();
        tx_chk = 1'b0;
    endtask

    task automatic bang_frame(input byte_t b, input bit flip_par, input bit bad_stop);
        logic v;
        build_frame(b);
        for (int i = 0; i < NB; i++)
        begin
            v = frame_bits[i[3:0]];
            if (flip_par && (P_BITS == 1) && (i == 9))
                v = !v;
            if (bad_stop && (i == 9 + P_BITS))
                v = 1'b0;
            bb_line = v;
            repeat (C) tick();
        end
        bb_line = 1'b1;
        repeat (C) tick();
    endtask

    // Event index selects parity_err (0), frame_err (1) or overrun (2)
    task automatic wait_event(input int which, input string what);
        int  n;
        bit  seen;
        seen = 1'b0;
        n = 0;
        while (!seen && (n < LIMIT))
        begin
            tick();
            n++;
            seen = (which == 0) ? rx_event.parity_err :
                   (which == 1) ? rx_event.frame_err : rx_event.overrun;
        end
        if (!seen)
        begin
            $display("Timeout waiting for the %s strobe", what);
            errors++;
        end
    endtask

    task automatic wait_not_empty();
        int n;
        n = 0;
        while (rx_status.empty && (n < LIMIT))
        begin
            tick();
            n++;
        end
        if (n >= LIMIT)
        begin
            $display("Timeout waiting for a byte in the receive FIFO");
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        tick();
        tests++;
        if (errors > err_before)
        begin
            failed++;
            $display("test %s: FAIL (%0d errors)", name, errors - err_before);
        end
        else
            $display("test %s: ok", name);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial
    begin
        byte_t sent [4];
        int    e;
        rst        = 1'b1;
        tx_start   = 1'b0;
        tx_data    = '0;
        rx_read    = 1'b0;
        rts        = 1'b0;
        bb_line    = 1'b1;
        loopback   = 1'b0;
        rst_chk    = 1'b0;
        tx_chk     = 1'b0;
        tx_exp     = 1'b1;
        len_chk    = 1'b0;
        busy_len   = 0;
        len_exp    = 0;
        data_chk   = 1'b0;
        data_exp   = '0;
        quiet      = 1'b0;
        empty_chk  = 1'b0;
        cts_chk    = 1'b0;
        cts_exp    = 1'b0;
        cnt_chk    = 1'b0;
        cnt_exp    = '0;
        full_exp   = 1'b0;
        cyc        = 0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        rng        = 32'ha229edce;
        frame_bits = '1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        e = errors;
        rst_chk   = 1'b1;
        empty_chk = 1'b1;
        tick();
        rst_chk   = 1'b0;
        empty_chk = 1'b0;
        report("reset_values", e);

        e = errors;
        for (int i = 0; i < 3; i++)
        begin
            rng = xorshift(rng);
            send_tx_byte(rng[7:0], i == 1);
        end
        report("transmit_framing", e);

        e = errors;
        loopback = 1'b1;
        quiet    = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            rng = xorshift(rng);
            sent[i] = rng[7:0];
            send_tx_byte(sent[i], 1'b0);
        end
        for (int i = 0; i < 4; i++)
        begin
            wait_not_empty();
            data_exp = sent[i];
            data_chk = 1'b1;
            rx_read  = 1'b1;
            tick();
            data_chk = 1'b0;
            rx_read  = 1'b0;
        end
        empty_chk = 1'b1;
        tick();
        empty_chk = 1'b0;
        quiet     = 1'b0;
        loopback  = 1'b0;
        report("loopback_order", e);

        e = errors;
        if (P_BITS == 1)
        begin
            fork
                bang_frame(8'h5a, 1'b1, 1'b0);
                wait_event(0, "parity_err");
            join
            empty_chk = 1'b1;
            repeat (C) tick();
            empty_chk = 1'b0;
            report("parity_error", e);
        end
        else
            $display("test parity_error: skipped, no parity bit");

        e = errors;
        fork
            bang_frame(8'hc3, 1'b0, 1'b1);
            wait_event(1, "frame_err");
        join
        empty_chk = 1'b1;
        repeat (C) tick();
        empty_chk = 1'b0;
        report("framing_error", e);

        e = errors;
        rts = 1'b1;
        tick();
        tick();
        cts_exp = 1'b1;
        cts_chk = 1'b1;
        tick();
        cts_chk = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            rng = xorshift(rng);
            sent[i] = rng[7:0];
            bang_frame(sent[i], 1'b0, 1'b0);
        end
        cts_exp  = 1'b0;
        cts_chk  = 1'b1;
        cnt_exp  = FIFO_COUNT_W'(4);
        full_exp = 1'b1;
        cnt_chk  = 1'b1;
        tick();
        cts_chk = 1'b0;
        cnt_chk = 1'b0;
        rng = xorshift(rng);
        fork
            bang_frame(rng[7:0], 1'b0, 1'b0);
            wait_event(2, "overrun");
        join
        data_exp = sent[0];
        data_chk = 1'b1;
        rx_read  = 1'b1;
        tick();
        data_chk = 1'b0;
        rx_read  = 1'b0;
        tick();
        cts_exp  = 1'b1;
        cts_chk  = 1'b1;
        data_exp = sent[1];
        data_chk = 1'b1;
        cnt_exp  = FIFO_COUNT_W'(3);
        full_exp = 1'b0;
        cnt_chk  = 1'b1;
        tick();
        cts_chk  = 1'b0;
        data_chk = 1'b0;
        cnt_chk  = 1'b0;
        report("flow_control_overrun", e);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/uart_line_pkg.sv
logic/uart_host_pkg.sv
logic/uart_bit_timer.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_rx_fifo.sv
logic/uart_rs232_top.sv
verification/uart_rs232_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench in three line formats with Verilator
run_cfg() {
    verilator --binary --top-module uart_rs232_tb -f list.f \
        -GTB_PARITY="$2" -GTB_STOP="$3" --Mdir "obj_$1" -o sim &&
    "./obj_$1/sim" > "log_$1.txt" 2>&1
}
rm -f log_none.txt log_even.txt log_odd.txt
run_cfg none 0 0 ; run_cfg even 1 0 ; run_cfg odd 2 1
grep -q "SIMULATION PASSED" log_none.txt && grep -q "SIMULATION PASSED" log_even.txt &&
grep -q "SIMULATION PASSED" log_odd.txt && echo "all configurations ok" ||
{ echo "a configuration failed, see log_*.txt"; exit 1; }
